/* gba_loader_pkg.sv */
// Loader package with download kinds, quirk flags, known title table and stream constants
package gba_loader_pkg;

	// ======================================================================
	// Download stream
	// ======================================================================

	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_CART,
		DL_CHEAT
	} dl_kind_t;

	localparam logic [7:0] IDX_BIOS  = 8'd0;    // Index of the BIOS image
	localparam logic [7:0] IDX_CHEAT = 8'd255;  // Index of the cheat file

	localparam int ADDR_W      = 27;  // Host byte address width
	localparam int BIOS_ADDR_W = 12;  // BIOS word address width
	localparam int CHEAT_W     = 128; // Flags, address, compare, replace

	// ======================================================================
	// Cartridge header and compatibility table
	// ======================================================================

	localparam logic [ADDR_W-1:0] HEADER_TITLE_ADDR = 27'h00000a0;
	localparam logic [ADDR_W-1:0] HEADER_CHECK_ADDR = 27'h00000ac; // First byte after the title

	localparam int TITLE_W     = 96;  // 12 ASCII bytes
	localparam int QUIRK_COUNT = 8;

	// Bit order follows the field order, sram is the MSB
	typedef struct packed {
		logic sram;
		logic remap;
		logic gpio;
		logic tilt;
		logic solar;
	} quirk_t;

	// Short titles are padded with zero bytes at the end
	localparam logic [TITLE_W-1:0] QUIRK_TITLES [QUIRK_COUNT] = '{
		{"ROCKY BOXING"},
		{"SUPER MARIO", 8'h00},
		{"DR. MARIO", 24'h000000},
		{"ZELDA 1", 40'h0000000000},
		{"POKEMON EMER"},
		{"WARIOTWISTED"},
		{"BOKTAI", 48'h000000000000},
		{"YOSHI TOPSY", 8'h00}
	};

	// Columns are sram, remap, gpio, tilt, solar
	localparam quirk_t QUIRK_FLAGS [QUIRK_COUNT] = '{
		quirk_t'(5'b10000),  // Rocky
		quirk_t'(5'b11000),  // NES classic
		quirk_t'(5'b11000),  // NES classic
		quirk_t'(5'b11000),  // NES classic
		quirk_t'(5'b00100),  // RTC through GPIO
		quirk_t'(5'b00100),  // Gyro through GPIO
		quirk_t'(5'b00101),  // Solar sensor
		quirk_t'(5'b00010)   // Tilt sensor
	};

	// Save type marker searched in the ROM image
	localparam logic [71:0] FLASH_TAG = "FLASH1M_V";

endpackage

/* download_if.sv */
// Interface for the classified and registered host download stream
interface download_if;

	gba_loader_pkg::dl_kind_t         kind;   // Kind of the running download
	logic [gba_loader_pkg::ADDR_W-1:0] addr;  // Byte address of the halfword
	logic [15:0]                       dout;  // Lower address byte in bits 7..0
	logic                              wr;    // One cycle per halfword
	logic                              start; // First cycle of a new kind

	modport source (
		output kind,
		output addr,
		output dout,
		output wr,
		output start
	);

	modport sink (
		input kind,
		input addr,
		input dout,
		input wr,
		input start
	);

endinterface

/* download_decode.sv */
// Host stream decoder with kind classification, stream registers and start strobe
module download_decode (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              ioctl_download,
	input  logic [7:0]                        ioctl_index,
	input  logic [gba_loader_pkg::ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]                       ioctl_dout,
	input  logic                              ioctl_wr,
	download_if.source                        dl
);

	gba_loader_pkg::dl_kind_t next_kind;

	// Every index that is neither BIOS nor cheats is a cartridge
	always_comb begin
		if (!ioctl_download)
			next_kind = gba_loader_pkg::DL_NONE;
		else if (ioctl_index == gba_loader_pkg::IDX_BIOS)
			next_kind = gba_loader_pkg::DL_BIOS;
		else if (ioctl_index == gba_loader_pkg::IDX_CHEAT)
			next_kind = gba_loader_pkg::DL_CHEAT;
		else
			next_kind = gba_loader_pkg::DL_CART;
	end

	// ======================================================================
	// Control registers
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl.kind  <= gba_loader_pkg::DL_NONE;
			dl.start <= 1'b0;
			dl.wr    <= 1'b0;
		end else begin
			dl.kind  <= next_kind;
			// Rising edge of a new kind, also a direct switch between kinds
			dl.start <= (next_kind != dl.kind) && (next_kind != gba_loader_pkg::DL_NONE);
			dl.wr    <= ioctl_wr;
		end
	end

	// Address and data follow the strobe in the same cycle
	always_ff @(posedge clk_sys) begin
		dl.addr <= ioctl_addr;
		dl.dout <= ioctl_dout;
	end

endmodule

/* cart_info.sv */
// Cartridge status with loaded flag, type, last pak address and FLASH1M tag search
module cart_info (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic [7:0]                          ioctl_index,
	download_if.sink                            dl,
	output logic                                cart_loaded,
	output logic [1:0]                          cart_type,
	output logic                                flash_1m,
	output logic [gba_loader_pkg::ADDR_W-3:0]   max_pak_addr
);

	// Holds the eight bytes before the current halfword
	logic [$bits(gba_loader_pkg::FLASH_TAG)-9:0] history;
	logic [$bits(gba_loader_pkg::FLASH_TAG)-9:0] hist_base;
	logic cart_start;
	logic cart_wr;
	logic tag_low;
	logic tag_high;

	assign cart_start = dl.start && (dl.kind == gba_loader_pkg::DL_CART);
	assign cart_wr    = dl.wr && (dl.kind == gba_loader_pkg::DL_CART);

	// A new image never continues a tag from the previous one
	assign hist_base = cart_start ? '0 : history;

	// Tag ends on the low byte or on the high byte of this halfword
	assign tag_low  = {hist_base, dl.dout[7:0]} == gba_loader_pkg::FLASH_TAG;
	assign tag_high = {hist_base[$bits(history)-9:0], dl.dout[7:0], dl.dout[15:8]}
		== gba_loader_pkg::FLASH_TAG;

	// ======================================================================
	// Status flags
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_loaded <= 1'b0;
			flash_1m    <= 1'b0;
		end else begin
			if (cart_start) begin
				cart_loaded <= 1'b1;
				flash_1m    <= 1'b0;
			end
			if (cart_wr && (tag_low || tag_high))
				flash_1m <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_start) begin
			cart_type <= ioctl_index[7:6];
			history   <= '0;
		end
		if (cart_wr) begin
			max_pak_addr <= dl.addr[gba_loader_pkg::ADDR_W-1:2]; // Word address of last write
			history      <= {hist_base[$bits(history)-17:0], dl.dout[7:0], dl.dout[15:8]};
		end
	end

endmodule

/* quirk_detect.sv */
// Header title capture and known title match into compatibility quirk flags
module quirk_detect (
	input  logic                   clk_sys,
	input  logic                   reset,
	download_if.sink               dl,
	output gba_loader_pkg::quirk_t quirks
);

	logic [gba_loader_pkg::TITLE_W-1:0] title;
	gba_loader_pkg::quirk_t matched;
	logic       cart_start;
	logic       cart_wr;
	logic       title_wr;
	logic       check_wr;
	logic [6:0] title_lsb;

	assign cart_start = dl.start && (dl.kind == gba_loader_pkg::DL_CART);
	assign cart_wr    = dl.wr && (dl.kind == gba_loader_pkg::DL_CART);

	// Title sits at 0xA0..0xAB, a 16 byte aligned window
	assign title_wr = cart_wr
		&& (dl.addr >= gba_loader_pkg::HEADER_TITLE_ADDR)
		&& (dl.addr < gba_loader_pkg::HEADER_CHECK_ADDR);
	assign check_wr = cart_wr && (dl.addr == gba_loader_pkg::HEADER_CHECK_ADDR);

	// First title byte lands in the top bits, like a string literal
	assign title_lsb = 7'(gba_loader_pkg::TITLE_W - 16) - {dl.addr[3:1], 4'b0000};

	// ======================================================================
	// Table compare
	// ======================================================================

	always_comb begin
		matched = '0;
		for (int i = 0; i < gba_loader_pkg::QUIRK_COUNT; i++) begin
			if (title == gba_loader_pkg::QUIRK_TITLES[i])
				matched = gba_loader_pkg::quirk_t'(matched | gba_loader_pkg::QUIRK_FLAGS[i]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (title_wr)
			title[title_lsb +: 16] <= {dl.dout[7:0], dl.dout[15:8]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			quirks <= '0;
		end else if (cart_start) begin
			quirks <= '0;                  // Flags belong to one image only
		end else if (check_wr) begin
			quirks <= gba_loader_pkg::quirk_t'(quirks | matched);
		end
	end

endmodule

/* bios_writer.sv */
// BIOS word packer producing 32-bit write strobes from host halfwords
module bios_writer (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  bios_disable,
	download_if.sink                              dl,
	output logic                                  bios_wr,
	output logic [gba_loader_pkg::BIOS_ADDR_W-1:0] bios_wraddr,
	output logic [31:0]                           bios_wrdata
);

	logic bios_hw;

	// Homebrew BIOS mode keeps the built-in image untouched
	assign bios_hw = dl.wr && (dl.kind == gba_loader_pkg::DL_BIOS) && !bios_disable;

	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_hw && dl.addr[1];  // Word is complete with the high half
	end

	always_ff @(posedge clk_sys) begin
		if (bios_hw) begin
			if (!dl.addr[1]) begin
				bios_wrdata[15:0] <= dl.dout;
			end else begin
				bios_wrdata[31:16] <= dl.dout;
				bios_wraddr        <= dl.addr[gba_loader_pkg::BIOS_ADDR_W+1:2];
			end
		end
	end

endmodule

/* cheat_assembler.sv */
// Cheat code packer with 128-bit code assembly, valid strobe and clear strobe
module cheat_assembler (
	input  logic                              clk_sys,
	input  logic                              reset,
	download_if.sink                          dl,
	output logic                              cheat_clear,
	output logic                              cheat_valid,
	output logic [gba_loader_pkg::CHEAT_W-1:0] cheat_code
);

	logic       cheat_start;
	logic       cheat_wr;
	logic [6:0] code_lsb;

	assign cheat_start = dl.start && (dl.kind == gba_loader_pkg::DL_CHEAT);
	assign cheat_wr    = dl.wr && (dl.kind == gba_loader_pkg::DL_CHEAT) && !dl.addr[0];

	// ======================================================================
	// Code layout, top to bottom: flags, address, compare, replace
	// ======================================================================

	// Field 0 sits at the top, low halfword of each field first
	assign code_lsb = {~dl.addr[3:2], dl.addr[1], 4'b0000};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_clear <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_clear <= cheat_start;
			cheat_valid <= cheat_wr && (dl.addr[3:0] == 4'd14); // Replace top word ends the code
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cheat_wr)
			cheat_code[code_lsb +: 16] <= dl.dout;
	end

endmodule

/* gba_loader.sv */
// Cartridge loader top level with host stream ports, stream interface and loader blocks
module gba_loader (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic [gba_loader_pkg::ADDR_W-1:0]     ioctl_addr,
	input  logic [15:0]                           ioctl_dout,
	input  logic                                  ioctl_wr,
	input  logic                                  bios_disable,
	output logic                                  cart_loaded,
	output logic [1:0]                            cart_type,
	output logic                                  flash_1m,
	output logic [gba_loader_pkg::ADDR_W-3:0]     max_pak_addr,
	output logic                                  bios_wr,
	output logic [gba_loader_pkg::BIOS_ADDR_W-1:0] bios_wraddr,
	output logic [31:0]                           bios_wrdata,
	output logic                                  cheat_clear,
	output logic                                  cheat_valid,
	output logic [gba_loader_pkg::CHEAT_W-1:0]    cheat_code,
	output logic                                  sram_quirk,
	output logic                                  memory_remap_quirk,
	output logic                                  gpio_quirk,
	output logic                                  tilt_quirk,
	output logic                                  solar_quirk
);

	download_if dl ();

	gba_loader_pkg::quirk_t quirks;

	// Registered stream shared by all consumers
	download_decode download_decode_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.dl             (dl.source)
	);

	cart_info cart_info_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ioctl_index  (ioctl_index),
		.dl           (dl.sink),
		.cart_loaded  (cart_loaded),
		.cart_type    (cart_type),
		.flash_1m     (flash_1m),
		.max_pak_addr (max_pak_addr)
	);

	quirk_detect quirk_detect_i (.clk_sys(clk_sys), .reset(reset), .dl(dl.sink), .quirks(quirks));

	bios_writer bios_writer_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bios_disable (bios_disable),
		.dl           (dl.sink),
		.bios_wr      (bios_wr),
		.bios_wraddr  (bios_wraddr),
		.bios_wrdata  (bios_wrdata)
	);

	cheat_assembler cheat_assembler_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.cheat_clear (cheat_clear),
		.cheat_valid (cheat_valid),
		.cheat_code  (cheat_code)
	);

	assign sram_quirk         = quirks.sram;
	assign memory_remap_quirk = quirks.remap;
	assign gpio_quirk         = quirks.gpio;
	assign tilt_quirk         = quirks.tilt;
	assign solar_quirk        = quirks.solar;

endmodule

/* tb_gba_loader.sv */
// Testbench for the cartridge loader with stimulus tasks, reference functions, checkers and report
module tb_gba_loader;

	logic                                   clk_sys = 1'b0;
	logic                                   reset;
	logic                                   ioctl_download;
	logic [7:0]                             ioctl_index;
	logic [gba_loader_pkg::ADDR_W-1:0]      ioctl_addr;
	logic [15:0]                            ioctl_dout;
	logic                                   ioctl_wr;
	logic                                   bios_disable;
	logic                                   cart_loaded;
	logic [1:0]                             cart_type;
	logic                                   flash_1m;
	logic [gba_loader_pkg::ADDR_W-3:0]      max_pak_addr;
	logic                                   bios_wr;
	logic [gba_loader_pkg::BIOS_ADDR_W-1:0] bios_wraddr;
	logic [31:0]                            bios_wrdata;
	logic                                   cheat_clear;
	logic                                   cheat_valid;
	logic [gba_loader_pkg::CHEAT_W-1:0]     cheat_code;
	logic                                   sram_quirk;
	logic                                   memory_remap_quirk;
	logic                                   gpio_quirk;
	logic                                   tilt_quirk;
	logic                                   solar_quirk;

	int mismatch_count = 0;
	int other_errors   = 0;
	int clear_count    = 0;

	logic [7:0]                             image [256]; // Cartridge bytes by byte address
	logic [31:0]                            bios_words [$];
	logic [gba_loader_pkg::BIOS_ADDR_W-1:0] bios_addrs [$];
	logic [gba_loader_pkg::CHEAT_W-1:0]     codes [$];

	always #5 clk_sys = ~clk_sys;

	gba_loader gba_loader_i (.*);

	// ======================================================================
	// Reference functions
	// ======================================================================

	function automatic logic [31:0] join_halfwords(input logic [15:0] lo, input logic [15:0] hi);
		return {hi, lo};
	endfunction

	function automatic logic [gba_loader_pkg::BIOS_ADDR_W-1:0] bios_word_addr(
		input logic [gba_loader_pkg::ADDR_W-1:0] addr);
		return addr[13:2];
	endfunction

	function automatic logic [gba_loader_pkg::ADDR_W-3:0] pak_word_addr(
		input logic [gba_loader_pkg::ADDR_W-1:0] addr);
		return addr[gba_loader_pkg::ADDR_W-1:2];
	endfunction

	// Flags, address, compare and replace from the top down with the low halfword first
	function automatic logic [gba_loader_pkg::CHEAT_W-1:0] pack_cheat_code(
		input logic [15:0] hw [8]);
		return {hw[1], hw[0], hw[3], hw[2], hw[5], hw[4], hw[7], hw[6]};
	endfunction

	// Flags of the table entry with this title and none for an unknown title
	function automatic gba_loader_pkg::quirk_t title_quirks(
		input logic [gba_loader_pkg::TITLE_W-1:0] title);
		for (int i = 0; i < gba_loader_pkg::QUIRK_COUNT; i++) begin
			if (title == gba_loader_pkg::QUIRK_TITLES[i])
				return gba_loader_pkg::QUIRK_FLAGS[i];
		end
		return '0;
	endfunction

	// Byte search over the image at any alignment
	function automatic logic image_has_tag(input int len);
		logic found;
		logic hit;
		found = 1'b0;
		for (int i = 0; i + 9 <= len; i++) begin
			hit = 1'b1;
			for (int k = 0; k < 9; k++) begin
				if (image[i+k] != gba_loader_pkg::FLASH_TAG[71-8*k -: 8])
					hit = 1'b0;
			end
			found = found | hit;
		end
		return found;
	endfunction

	function automatic gba_loader_pkg::quirk_t dut_quirks();
		gba_loader_pkg::quirk_t q;
		q.sram  = sram_quirk;
		q.remap = memory_remap_quirk;
		q.gpio  = gpio_quirk;
		q.tilt  = tilt_quirk;
		q.solar = solar_quirk;
		return q;
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic check_code(input string name, input logic [gba_loader_pkg::CHEAT_W-1:0] expected,
		input logic [gba_loader_pkg::CHEAT_W-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic check_quirks(input string name, input gba_loader_pkg::quirk_t expected,
		input gba_loader_pkg::quirk_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
			mismatch_count++;
		end
	endtask

	// Each strobe is matched with the head of its queue
	always @(negedge clk_sys) begin
		logic [31:0]                            exp_word;
		logic [gba_loader_pkg::BIOS_ADDR_W-1:0] exp_addr;
		logic [gba_loader_pkg::CHEAT_W-1:0]     exp_code;
		if (!reset && bios_wr) begin
			if (bios_words.size() == 0) begin
				$display("Unexpected BIOS write strobe at word address %h", bios_wraddr);
				other_errors++;
			end else begin
				exp_word = bios_words.pop_front();
				exp_addr = bios_addrs.pop_front();
				check_word("bios data", exp_word, bios_wrdata);
				check_word("bios address", 32'(exp_addr), 32'(bios_wraddr));
			end
		end
		if (!reset && cheat_valid) begin
			if (codes.size() == 0) begin
				$display("Unexpected cheat valid strobe");
				other_errors++;
			end else begin
				exp_code = codes.pop_front();
				check_code("cheat code", exp_code, cheat_code);
			end
		end
		if (!reset && cheat_clear)
			clear_count++;
	end

	// ======================================================================
	// Stimulus tasks entered and left on a falling edge
	// ======================================================================

	task automatic send_halfword(input logic [gba_loader_pkg::ADDR_W-1:0] addr,
		input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic open_download(input logic [7:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic close_download();
		ioctl_download = 1'b0;
		repeat (4) @(negedge clk_sys); // Status lags the last write by two cycles
	endtask

	task automatic load_image(input logic [7:0] index, input int len);
		open_download(index);
		for (int a = 0; a < len; a += 2)
			send_halfword(27'(a), {image[a+1], image[a]});
		close_download();
	endtask

	task automatic fill_random(input int len);
		for (int i = 0; i < len; i++)
			image[i] = 8'($urandom);
	endtask

	task automatic place_tag(input int offset);
		for (int k = 0; k < 9; k++)
			image[offset+k] = gba_loader_pkg::FLASH_TAG[71-8*k -: 8];
	endtask

	task automatic place_title(input logic [gba_loader_pkg::TITLE_W-1:0] title);
		for (int k = 0; k < 12; k++)
			image[8'ha0+k] = title[95-8*k -: 8];
	endtask

	task automatic wait_queues_empty(input string what);
		int cycles = 0;
		while ((bios_words.size() != 0 || codes.size() != 0) && cycles < 200) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (bios_words.size() != 0 || codes.size() != 0) begin
			$display("Timeout: expected %s write strobes never arrived", what);
			other_errors++;
		end
	endtask

	task automatic wait_clear(input int count);
		int cycles = 0;
		while (clear_count < count && cycles < 20) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (clear_count < count) begin
			$display("Timeout: cheat clear strobe did not come after the cheat download started");
			other_errors++;
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic [15:0]                       lo;
		logic [15:0]                       hi;
		logic [15:0]                       hw [8];
		logic [gba_loader_pkg::ADDR_W-1:0] base;
		logic [gba_loader_pkg::TITLE_W-1:0] title;
		void'($urandom(32'ha778_ef1d));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = 16'd0;
		ioctl_wr       = 1'b0;
		bios_disable   = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_bit("cart loaded after reset", 1'b0, cart_loaded);
		check_bit("flash after reset", 1'b0, flash_1m);
		check_quirks("quirks after reset", '0, dut_quirks());

		// BIOS words from a random start and again with loading disabled
		base = 27'(($urandom % 1024) * 4);
		open_download(gba_loader_pkg::IDX_BIOS);
		for (int i = 0; i < 16; i++) begin
			lo = 16'($urandom);
			hi = 16'($urandom);
			bios_words.push_back(join_halfwords(lo, hi));
			bios_addrs.push_back(bios_word_addr(base + 27'(4*i) + 27'd2));
			send_halfword(base + 27'(4*i), lo);
			send_halfword(base + 27'(4*i) + 27'd2, hi);
		end
		close_download();
		wait_queues_empty("BIOS");
		bios_disable = 1'b1;
		open_download(gba_loader_pkg::IDX_BIOS);
		for (int i = 0; i < 8; i++)
			send_halfword(27'(2*i), 16'($urandom));
		close_download();
		bios_disable = 1'b0;

		// Plain cartridge with the type from index bits 7..6
		fill_random(64);
		load_image(8'h80, 64);
		check_bit("cart loaded", 1'b1, cart_loaded);
		check_word("cart type", 32'd2, 32'(cart_type));
		check_word("last pak address", 32'(pak_word_addr(27'd62)), 32'(max_pak_addr));

		// FLASH1M tag at an even offset, at an odd offset and absent
		fill_random(128);
		place_tag(8'h40);
		load_image(8'h81, 128);
		check_bit("flash tag even", image_has_tag(128), flash_1m);
		fill_random(128);
		place_tag(8'h51);
		load_image(8'h82, 128);
		check_bit("flash tag odd", image_has_tag(128), flash_1m);
		fill_random(128);
		load_image(8'h83, 128);
		check_bit("flash tag absent", image_has_tag(128), flash_1m);

		// Unknown title first and then every table entry
		for (int t = 0; t <= gba_loader_pkg::QUIRK_COUNT; t++) begin
			if (t == 0)
				title = "NOT A TITLE!";
			else
				title = gba_loader_pkg::QUIRK_TITLES[t-1];
			fill_random(8'hb0);
			place_title(title);
			load_image(8'h40, 8'hb0);
			check_quirks($sformatf("quirks title %0d", t), title_quirks(title), dut_quirks());
		end
		fill_random(64);
		load_image(8'h40, 64); // Ends before the header
		check_quirks("quirks cleared", '0, dut_quirks());

		// Cheat download with two codes
		open_download(gba_loader_pkg::IDX_CHEAT);
		wait_clear(1);
		for (int c = 0; c < 2; c++) begin
			for (int k = 0; k < 8; k++)
				hw[k] = 16'($urandom);
			codes.push_back(pack_cheat_code(hw));
			for (int k = 0; k < 8; k++)
				send_halfword(27'(16*c + 2*k), hw[k]);
		end
		close_download();
		wait_queues_empty("cheat");
		check_word("cheat clear count", 32'd1, 32'(clear_count));

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* gba_loader.f */
gba_loader_pkg.sv
download_if.sv
download_decode.sv
cart_info.sv
quirk_detect.sv
bios_writer.sv
cheat_assembler.sv
gba_loader.sv
tb_gba_loader.sv

/* run_sim.sh */
#!/bin/sh
# Builds the loader testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_gba_loader \
	-f gba_loader.f -o tb_gba_loader
if [ $? -ne 0 ]; then
	echo "Verilator build returned an error"
	exit 1
fi

./obj_dir/tb_gba_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi

exit 0
